/* src/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path and register width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32
`define REG_IDX_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* src/rv_isa_pkg.sv */
`include "core_consts.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;

  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_OP       = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store access width, shared by both
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // alu sub-operations of op and op-imm
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rd;
    opcode_e               opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`REG_IDX_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_type_t;

  // branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    logic [6:0]            opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [`REG_IDX_W-1:0] rd;
    logic [6:0]            opcode;
  } u_type_t;

  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`REG_IDX_W-1:0] rd;
    logic [6:0]            opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } insn_u;

endpackage

/* src/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui just forwards the immediate
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  use_pc;
    rv_isa_pkg::word_t     imm;
    logic                  reg_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic [2:0]            funct3;
    logic                  halt;
  } ctrl_t;

  // addr is word aligned, be picks the byte lanes
  typedef struct packed {
    rv_isa_pkg::word_t addr;
    rv_isa_pkg::word_t wdata;
    logic [3:0]        be;
  } dmem_req_t;

endpackage

/* src/insn_decoder.sv */
module insn_decoder (
  input  rv_isa_pkg::insn_u insn_i,
  output core_pkg::ctrl_t   ctrl_o
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic                alt;
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_s;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_u;
  rv_isa_pkg::word_t   imm_j;

  // maps funct3 plus the funct7 alternate bit onto an alu operation
  function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt_sel);
    core_pkg::alu_op_e op;
    op = core_pkg::ALU_ADD;
    case (f3)
      rv_isa_pkg::F3_ADD:  op = alt_sel ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   op = alt_sel ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   op = core_pkg::ALU_OR;
      rv_isa_pkg::F3_AND:  op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = insn_i.r.opcode;
  assign funct3 = insn_i.r.funct3;
  assign alt    = insn_i.r.funct7[5];

  // immediates, all sign extended from the top instruction bit
  assign imm_i = {{20{insn_i.i.imm[11]}}, insn_i.i.imm};
  assign imm_s = {{20{insn_i.s.imm_hi[6]}}, insn_i.s.imm_hi, insn_i.s.imm_lo};
  assign imm_b = {{20{insn_i.b.imm12}}, insn_i.b.imm11, insn_i.b.imm10_5,
                  insn_i.b.imm4_1, 1'b0};
  assign imm_u = {insn_i.u.imm, 12'b0};
  assign imm_j = {{12{insn_i.j.imm20}}, insn_i.j.imm19_12, insn_i.j.imm11,
                  insn_i.j.imm10_1, 1'b0};

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.rd     = insn_i.r.rd;
    ctrl_o.rs1    = insn_i.r.rs1;
    ctrl_o.rs2    = insn_i.r.rs2;
    ctrl_o.funct3 = funct3;
    ctrl_o.alu_op = core_pkg::ALU_ADD;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_u;
        ctrl_o.alu_op  = core_pkg::ALU_PASS_B;
      end
      rv_isa_pkg::OP_AUIPC: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.use_pc  = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_u;
      end
      rv_isa_pkg::OP_JAL: begin
        ctrl_o.reg_we = 1'b1;
        ctrl_o.is_jal = 1'b1;
        ctrl_o.imm    = imm_j;
      end
      rv_isa_pkg::OP_JALR: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.is_jalr = 1'b1;
        ctrl_o.imm     = imm_i;
      end
      rv_isa_pkg::OP_BRANCH: begin
        ctrl_o.is_branch = 1'b1;
        ctrl_o.imm       = imm_b;
      end
      rv_isa_pkg::OP_LOAD: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.is_load = 1'b1;
        ctrl_o.imm     = imm_i;
      end
      rv_isa_pkg::OP_STORE: begin
        ctrl_o.is_store = 1'b1;
        ctrl_o.imm      = imm_s;
      end
      rv_isa_pkg::OP_IMM: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_i;
        // bit 30 is part of the immediate except for the shifts
        ctrl_o.alu_op  = alu_decode(funct3, alt && (funct3 == rv_isa_pkg::F3_SR));
      end
      rv_isa_pkg::OP_OP: begin
        ctrl_o.reg_we = 1'b1;
        ctrl_o.alu_op = alu_decode(funct3, alt);
      end
      // ecall, fence and unknown opcodes park the core
      default: begin
        ctrl_o.halt = 1'b1;
      end
    endcase
  end

endmodule

/* src/reg_file.sv */
`include "core_consts.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_IDX_W-1:0] rd_i,
  input  logic [`REG_IDX_W-1:0] rs1_i,
  input  logic [`REG_IDX_W-1:0] rs2_i,
  input  logic                  we_i,
  input  rv_isa_pkg::word_t     rd_data_i,
  output rv_isa_pkg::word_t     rs1_data_o,
  output rv_isa_pkg::word_t     rs2_data_o
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* src/exec_unit.sv */
`include "core_consts.svh"

module exec_unit (
  input  rv_isa_pkg::word_t pc_i,
  input  core_pkg::ctrl_t   ctrl_i,
  input  rv_isa_pkg::word_t rs1_data_i,
  input  rv_isa_pkg::word_t rs2_data_i,
  output rv_isa_pkg::word_t result_o,
  output rv_isa_pkg::word_t addr_o,
  output rv_isa_pkg::word_t next_pc_o
);

  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t op_b;
  rv_isa_pkg::word_t alu_out;
  rv_isa_pkg::word_t pc_plus4;
  rv_isa_pkg::word_t target;
  logic [4:0]        shamt;
  logic              eq;
  logic              lt;
  logic              ltu;
  logic              taken;

  assign op_a  = ctrl_i.use_pc ? pc_i : rs1_data_i;
  assign op_b  = ctrl_i.use_imm ? ctrl_i.imm : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl_i.alu_op)
      core_pkg::ALU_ADD:  alu_out = op_a + op_b;
      core_pkg::ALU_SUB:  alu_out = op_a - op_b;
      core_pkg::ALU_SLL:  alu_out = op_a << shamt;
      core_pkg::ALU_SLT:  alu_out = rv_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
      core_pkg::ALU_SLTU: alu_out = rv_isa_pkg::word_t'(op_a < op_b);
      core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      core_pkg::ALU_SRL:  alu_out = op_a >> shamt;
      core_pkg::ALU_SRA:  alu_out = rv_isa_pkg::word_t'($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:   alu_out = op_a | op_b;
      core_pkg::ALU_AND:  alu_out = op_a & op_b;
      default:            alu_out = op_b;
    endcase
  end

  // branch compare always works on the two register operands
  assign eq  = rs1_data_i == rs2_data_i;
  assign lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
  assign ltu = rs1_data_i < rs2_data_i;

  always_comb begin
    case (ctrl_i.funct3)
      rv_isa_pkg::F3_BEQ:  taken = eq;
      rv_isa_pkg::F3_BNE:  taken = !eq;
      rv_isa_pkg::F3_BLT:  taken = lt;
      rv_isa_pkg::F3_BGE:  taken = !lt;
      rv_isa_pkg::F3_BLTU: taken = ltu;
      rv_isa_pkg::F3_BGEU: taken = !ltu;
      default:             taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc_i + `XLEN'd4;
  assign target   = pc_i + ctrl_i.imm;
  // load/store address, also the jalr target before bit 0 is dropped
  assign addr_o   = rs1_data_i + ctrl_i.imm;

  // jumps link the return address
  assign result_o = (ctrl_i.is_jal || ctrl_i.is_jalr) ? pc_plus4 : alu_out;

  always_comb begin
    if (ctrl_i.is_jalr) begin
      next_pc_o = {addr_o[`XLEN-1:1], 1'b0};
    end else if (ctrl_i.is_jal || (ctrl_i.is_branch && taken)) begin
      next_pc_o = target;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

endmodule

/* src/lsu.sv */
module lsu (
  input  core_pkg::ctrl_t     ctrl_i,
  input  rv_isa_pkg::word_t   addr_i,
  input  rv_isa_pkg::word_t   rs2_data_i,
  input  rv_isa_pkg::word_t   result_i,
  input  rv_isa_pkg::word_t   dmem_rdata_i,
  output core_pkg::dmem_req_t dmem_req_o,
  output rv_isa_pkg::word_t   wb_data_o
);

  logic [1:0]        ofs;
  rv_isa_pkg::word_t lane;

  assign ofs  = addr_i[1:0];
  // addressed byte or halfword moved down to bit 0
  assign lane = dmem_rdata_i >> {ofs, 3'b000};

  always_comb begin
    dmem_req_o.addr  = {addr_i[31:2], 2'b00};
    dmem_req_o.wdata = rs2_data_i << {ofs, 3'b000};
    dmem_req_o.be    = 4'b0000;
    if (ctrl_i.is_store) begin
      case (ctrl_i.funct3)
        rv_isa_pkg::F3_B: dmem_req_o.be = 4'b0001 << ofs;
        rv_isa_pkg::F3_H: dmem_req_o.be = 4'b0011 << {ofs[1], 1'b0};
        rv_isa_pkg::F3_W: dmem_req_o.be = 4'b1111;
        default:          dmem_req_o.be = 4'b0000;
      endcase
    end
  end

  always_comb begin
    wb_data_o = result_i;
    if (ctrl_i.is_load) begin
      case (ctrl_i.funct3)
        rv_isa_pkg::F3_B:  wb_data_o = {{24{lane[7]}}, lane[7:0]};
        rv_isa_pkg::F3_H:  wb_data_o = {{16{lane[15]}}, lane[15:0]};
        rv_isa_pkg::F3_BU: wb_data_o = {24'b0, lane[7:0]};
        rv_isa_pkg::F3_HU: wb_data_o = {16'b0, lane[15:0]};
        default:           wb_data_o = lane;
      endcase
    end
  end

  always_comb begin
    if (ctrl_i.is_load || ctrl_i.is_store) begin
      if ((ctrl_i.funct3 == rv_isa_pkg::F3_H) || (ctrl_i.funct3 == rv_isa_pkg::F3_HU)) begin
        assert (ofs[0] == 1'b0)
          else $error("misaligned halfword access at %h", addr_i);
      end else if (ctrl_i.funct3 == rv_isa_pkg::F3_W) begin
        assert (ofs == 2'b00)
          else $error("misaligned word access at %h", addr_i);
      end
    end
  end

endmodule

/* src/riscv_core.sv */
`include "core_consts.svh"

module riscv_core (
  input  logic                clk,
  input  logic                rst,
  output rv_isa_pkg::word_t   imem_addr_o,
  input  rv_isa_pkg::word_t   imem_data_i,
  output core_pkg::dmem_req_t dmem_req_o,
  input  rv_isa_pkg::word_t   dmem_rdata_i,
  output logic                halt_o
);

  rv_isa_pkg::insn_u insn;
  core_pkg::ctrl_t   ctrl;
  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t next_pc;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t result;
  rv_isa_pkg::word_t addr;
  rv_isa_pkg::word_t wb_data;

  // pc parks on the halting instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else if (!ctrl.halt) begin
      pc <= next_pc;
    end
  end

  assign insn        = imem_data_i;
  assign imem_addr_o = pc;
  assign halt_o      = ctrl.halt;

  insn_decoder u_decoder (
    .insn_i (insn),
    .ctrl_o (ctrl)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .rst        (rst),
    .rd_i       (ctrl.rd),
    .rs1_i      (ctrl.rs1),
    .rs2_i      (ctrl.rs2),
    .we_i       (ctrl.reg_we && !ctrl.halt),
    .rd_data_i  (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  exec_unit u_exec_unit (
    .pc_i       (pc),
    .ctrl_i     (ctrl),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .result_o   (result),
    .addr_o     (addr),
    .next_pc_o  (next_pc)
  );

  lsu u_lsu (
    .ctrl_i       (ctrl),
    .addr_i       (addr),
    .rs2_data_i   (rs2_data),
    .result_i     (result),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_req_o   (dmem_req_o),
    .wb_data_o    (wb_data)
  );

  // jalr clears only bit 0, so a bad rs1 would show up here
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  // free running, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

/* dv/riscv_core_tb.sv */
module riscv_core_tb;

  localparam int CLK_PERIOD    = 100;
  localparam int NUM_TESTS     = 6;
  localparam int TEST_CYCLES   = 200;
  localparam int RUN_LIMIT     = 80;
  localparam int WATCHDOG_TIME = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

  // major opcodes from the RV32I base encoding
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam rv_isa_pkg::word_t ECALL_WORD = 32'h0000_0073;
  localparam rv_isa_pkg::word_t FENCE_WORD = 32'h0ff0_000f;

  logic                clk;
  logic                rst;
  rv_isa_pkg::word_t   imem_addr;
  rv_isa_pkg::word_t   imem_data;
  core_pkg::dmem_req_t dmem_req;
  rv_isa_pkg::word_t   dmem_rdata;
  logic                halt;

  rv_isa_pkg::word_t imem [256];
  rv_isa_pkg::word_t dmem [256];
  rv_isa_pkg::word_t prog [$];
  logic [3:0]        be_log [$];
  int                errors;
  int                failed_tests;

  tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.clk_o(clk));

  riscv_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_req_o   (dmem_req),
    .dmem_rdata_i (dmem_rdata),
    .halt_o       (halt)
  );

  // both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  function automatic rv_isa_pkg::word_t fill_word(input int idx);
    return 32'hd00d_0000 | rv_isa_pkg::word_t'(idx);
  endfunction

  // refilled during every reset, written per byte lane otherwise
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
      be_log.delete();
    end else if (dmem_req.be != 4'b0000) begin
      for (int l = 0; l < 4; l++) begin
        if (dmem_req.be[l]) begin
          dmem[dmem_req.addr[9:2]][8*l +: 8] <= dmem_req.wdata[8*l +: 8];
        end
      end
      be_log.push_back(dmem_req.be);
    end
  end

  function automatic rv_isa_pkg::word_t r_insn(input int f7, input int rs2, input int rs1,
                                               input int f3, input int rd, input logic [6:0] op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_isa_pkg::word_t i_insn(input int imm, input int rs1, input int f3,
                                               input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_isa_pkg::word_t s_insn(input int imm, input int rs2, input int rs1,
                                               input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
  endfunction

  function automatic rv_isa_pkg::word_t b_insn(input int off, input int rs2, input int rs1,
                                               input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic rv_isa_pkg::word_t u_insn(input int imm20, input int rd,
                                               input logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic rv_isa_pkg::word_t j_insn(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  // addi sign-extends its 12 bits, so lui takes the rounded upper part
  function automatic void push_li(input int rd, input rv_isa_pkg::word_t value);
    rv_isa_pkg::word_t upper;
    upper = value + 32'h800;
    prog.push_back(u_insn(int'(upper >> 12), rd, OPC_LUI));
    prog.push_back(i_insn(int'(value), rd, 0, rd, OPC_IMM));
  endfunction

  // result of an OP or OP-IMM instruction as the ISA defines it
  function automatic rv_isa_pkg::word_t isa_result(input int f3, input bit alt,
                                                   input rv_isa_pkg::word_t a,
                                                   input rv_isa_pkg::word_t b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return (a < b) ? 32'd1 : 32'd0;
      4: return a ^ b;
      5: return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_be(input string name, input logic [3:0] expected,
                          input logic [3:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  // loads prog behind a fill of illegal opcodes, resets, runs until halt
  task automatic run_program(input string name, output bit halted);
    int cycles;
    for (int i = 0; i < 256; i++) begin
      imem[i] = rv_isa_pkg::word_t'(i) << 7;
    end
    for (int k = 0; k < prog.size(); k++) begin
      imem[k] = prog[k];
    end
    @(negedge clk);
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    halted = halt;
    if (!halted) begin
      $display("%s: core did not halt within %0d cycles", name, RUN_LIMIT);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
      failed_tests++;
    end
  endtask

  task automatic alu_ops_test();
    int                rr_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    bit                rr_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
    int                ri_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
    bit                ri_alt [9] = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t opnd;
    rv_isa_pkg::word_t expect_q [$];
    int                err_before;
    bit                halted;
    err_before = errors;
    // negative a and positive b keep slt apart from sltu and sra apart from srl
    a = $urandom() | 32'h8000_0000;
    b = ($urandom() & 32'h7fff_ffff) | 32'h1;
    prog.delete();
    push_li(1, a);
    push_li(2, b);
    for (int k = 0; k < 10; k++) begin
      prog.push_back(r_insn(rr_alt[k] ? 32 : 0, 2, 1, rr_f3[k], 3, OPC_OP));
      prog.push_back(s_insn(256 + 4 * expect_q.size(), 3, 0, 2));
      expect_q.push_back(isa_result(rr_f3[k], rr_alt[k], a, b));
    end
    for (int k = 0; k < 9; k++) begin
      // shifts carry shamt and the arithmetic bit in the immediate
      if (ri_f3[k] == 1 || ri_f3[k] == 5) begin
        opnd = rv_isa_pkg::word_t'($urandom_range(31, 1));
        imm  = opnd | (ri_alt[k] ? 32'h400 : 32'h0);
      end else begin
        imm  = $urandom() & 32'hfff;
        opnd = {{20{imm[11]}}, imm[11:0]};
      end
      prog.push_back(i_insn(int'(imm), 1, ri_f3[k], 3, OPC_IMM));
      prog.push_back(s_insn(256 + 4 * expect_q.size(), 3, 0, 2));
      expect_q.push_back(isa_result(ri_f3[k], ri_alt[k], a, opnd));
    end
    prog.push_back(ECALL_WORD);
    run_program("alu_ops", halted);
    if (halted) begin
      for (int k = 0; k < expect_q.size(); k++) begin
        check_word($sformatf("alu_ops[%0d]", k), expect_q[k], dmem[64 + k]);
      end
    end
    report_test("alu_ops", err_before);
  endtask

  task automatic upper_imm_test();
    rv_isa_pkg::word_t u1;
    rv_isa_pkg::word_t u2;
    int                err_before;
    bit                halted;
    err_before = errors;
    u1 = $urandom() & 32'hf_ffff;
    u2 = $urandom() & 32'hf_ffff;
    prog.delete();
    prog.push_back(u_insn(int'(u1), 1, OPC_LUI));
    prog.push_back(s_insn(32'h100, 1, 0, 2));
    // auipc sits at pc 8
    prog.push_back(u_insn(int'(u2), 2, OPC_AUIPC));
    prog.push_back(s_insn(32'h104, 2, 0, 2));
    prog.push_back(ECALL_WORD);
    run_program("upper_imm", halted);
    if (halted) begin
      check_word("upper_imm lui", u1 << 12, dmem[64]);
      check_word("upper_imm auipc", 32'd8 + (u2 << 12), dmem[65]);
    end
    report_test("upper_imm", err_before);
  endtask

  task automatic branch_test();
    // x1 = -1, x2 = x3 = 1; even entries have the taken operand order
    int                br_f3 [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    int                br_rs1 [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    int                br_rs2 [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    rv_isa_pkg::word_t expected;
    int                err_before;
    bit                halted;
    err_before = errors;
    prog.delete();
    prog.push_back(i_insn(-1, 0, 0, 1, OPC_IMM));
    prog.push_back(i_insn(1, 0, 0, 2, OPC_IMM));
    prog.push_back(i_insn(1, 0, 0, 3, OPC_IMM));
    prog.push_back(i_insn(32'h5a5, 0, 0, 4, OPC_IMM));
    for (int k = 0; k < 12; k++) begin
      // a taken branch jumps over its marker store
      prog.push_back(b_insn(8, br_rs2[k], br_rs1[k], br_f3[k]));
      prog.push_back(s_insn(256 + 4 * k, 4, 0, 2));
    end
    prog.push_back(ECALL_WORD);
    run_program("branches", halted);
    if (halted) begin
      for (int k = 0; k < 12; k++) begin
        expected = (k % 2 == 0) ? fill_word(64 + k) : 32'h5a5;
        check_word($sformatf("branches[%0d] f3=%0d", k, br_f3[k]), expected, dmem[64 + k]);
      end
    end
    report_test("branches", err_before);
  endtask

  task automatic jump_test();
    int err_before;
    bit halted;
    err_before = errors;
    prog.delete();
    // jal at pc 0 lands at pc 12
    prog.push_back(j_insn(12, 1));
    prog.push_back(s_insn(32'h10c, 0, 0, 2));
    prog.push_back(s_insn(32'h10c, 0, 0, 2));
    prog.push_back(s_insn(32'h100, 1, 0, 2));
    prog.push_back(i_insn(37, 0, 0, 6, OPC_IMM));
    // jalr at pc 20, target 37 + 4 with bit 0 cleared is 40
    prog.push_back(i_insn(4, 6, 0, 2, OPC_JALR));
    for (int k = 0; k < 4; k++) begin
      prog.push_back(s_insn(32'h10c, 0, 0, 2));
    end
    prog.push_back(s_insn(32'h104, 2, 0, 2));
    prog.push_back(ECALL_WORD);
    run_program("jumps", halted);
    if (halted) begin
      check_word("jumps jal link", 32'd0 + 32'd4, dmem[64]);
      check_word("jumps jalr link", 32'd20 + 32'd4, dmem[65]);
      check_word("jumps skipped path", fill_word(67), dmem[67]);
      // an uncleared bit 0 would park the core at 45
      check_word("jumps halt pc", 32'd44, imem_addr);
    end
    report_test("jumps", err_before);
  endtask

  task automatic subword_test();
    rv_isa_pkg::word_t v;
    rv_isa_pkg::word_t w;
    logic [7:0]        bt;
    logic [15:0]       hw;
    rv_isa_pkg::word_t expect_q [$];
    logic [3:0]        be_q [$];
    int                err_before;
    bit                halted;
    err_before = errors;
    // top bit of each halfword set so the sign extension shows
    v = $urandom() | 32'h8000_8000;
    prog.delete();
    push_li(1, v);
    // each sb and sh goes to its own word, in the lane of its offset
    for (int ofs = 0; ofs < 4; ofs++) begin
      prog.push_back(s_insn(32'h100 + 5 * ofs, 1, 0, 0));
      be_q.push_back(4'b0001 << ofs);
    end
    for (int j = 0; j < 2; j++) begin
      prog.push_back(s_insn(32'h110 + 6 * j, 1, 0, 1));
      be_q.push_back(4'b0011 << (2 * j));
    end
    prog.push_back(s_insn(32'h120, 1, 0, 2));
    be_q.push_back(4'b1111);
    for (int k = 0; k < 12; k++) begin
      if (k < 8) begin
        bt = v[8 * (k % 4) +: 8];
        prog.push_back(i_insn(32'h120 + k % 4, 0, (k < 4) ? 0 : 4, 3, OPC_LOAD));
        expect_q.push_back((k < 4) ? {{24{bt[7]}}, bt} : {24'b0, bt});
      end else begin
        hw = v[16 * (k % 2) +: 16];
        prog.push_back(i_insn(32'h120 + 2 * (k % 2), 0, (k < 10) ? 1 : 5, 3, OPC_LOAD));
        expect_q.push_back((k < 10) ? {{16{hw[15]}}, hw} : {16'b0, hw});
      end
      prog.push_back(s_insn(32'h140 + 4 * k, 3, 0, 2));
      be_q.push_back(4'b1111);
    end
    prog.push_back(ECALL_WORD);
    run_program("subword", halted);
    if (halted) begin
      for (int ofs = 0; ofs < 4; ofs++) begin
        w = fill_word(64 + ofs);
        w[8*ofs +: 8] = v[7:0];
        check_word($sformatf("subword sb ofs %0d", ofs), w, dmem[64 + ofs]);
      end
      for (int j = 0; j < 2; j++) begin
        w = fill_word(68 + j);
        w[16*j +: 16] = v[15:0];
        check_word($sformatf("subword sh ofs %0d", 2 * j), w, dmem[68 + j]);
      end
      for (int k = 0; k < 12; k++) begin
        check_word($sformatf("subword load[%0d]", k), expect_q[k], dmem[80 + k]);
      end
      if (be_log.size() != be_q.size()) begin
        $display("subword: saw %0d stores, expected %0d", be_log.size(), be_q.size());
        errors++;
      end else begin
        for (int k = 0; k < be_q.size(); k++) begin
          check_be($sformatf("subword be[%0d]", k), be_q[k], be_log[k]);
        end
      end
    end
    report_test("subword", err_before);
  endtask

  task automatic halt_case(input string name, input rv_isa_pkg::word_t stop_insn);
    rv_isa_pkg::word_t snap [256];
    bit                halted;
    prog.delete();
    prog.push_back(i_insn(9, 0, 0, 1, OPC_IMM));
    prog.push_back(s_insn(32'h100, 1, 0, 2));
    prog.push_back(stop_insn);
    // never reached while parked
    prog.push_back(s_insn(32'h104, 1, 0, 2));
    run_program(name, halted);
    if (halted) begin
      check_word(name, 32'd8, imem_addr);
      check_word(name, 32'd9, dmem[64]);
      snap = dmem;
      repeat (5) begin
        @(negedge clk);
        if (!halt) begin
          $display("%s: halt output dropped while parked", name);
          errors++;
        end
        check_word(name, 32'd8, imem_addr);
      end
      for (int i = 0; i < 256; i++) begin
        check_word($sformatf("%s word %0d", name, i), snap[i], dmem[i]);
      end
    end
  endtask

  task automatic halt_test();
    int err_before;
    err_before = errors;
    halt_case("halt ecall", ECALL_WORD);
    halt_case("halt fence", FENCE_WORD);
    report_test("halt", err_before);
  endtask

  initial begin
    rst = 1'b1;
    errors = 0;
    failed_tests = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = rv_isa_pkg::word_t'(i) << 7;
    end
    void'($urandom(60));
    alu_ops_test();
    upper_imm_test();
    branch_test();
    jump_test();
    subword_test();
    halt_test();
    $display("tests run: %0d, tests failed: %0d, check errors: %0d",
             NUM_TESTS, failed_tests, errors);
    if (failed_tests == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog: run exceeded %0d time units", WATCHDOG_TIME);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* riscv_core.f */
+incdir+src
src/rv_isa_pkg.sv
src/core_pkg.sv
src/insn_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/lsu.sv
src/riscv_core.sv
dv/tb_clk_gen.sv
dv/riscv_core_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then decide on the log contents
verilator --binary --timing --assert --top-module riscv_core_tb -f riscv_core.f -o sim_core \
  && ./obj_dir/sim_core > sim.log 2>&1 \
  || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "result: FAIL"; exit 1; } \
  || { echo "result: PASS"; exit 0; }
